//--- build.f
src/pbuf_pkg.sv
src/dp_ram.sv
src/free_page_list.sv
src/pkt_ingress.sv
src/pkt_egress.sv
src/port_stats.sv
src/pbuf_top.sv
verification/pbuf_checker.sv
verification/pbuf_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pbuf_tb -f build.f -o pbuf_sim

status=0
result=$(./obj_dir/pbuf_sim 2>&1) || status=$?
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Simulation did not pass (exit status $status)."
exit 1

//--- src/dp_ram.sv
`timescale 1ns/100ps

module dp_ram #(
    parameter type word_type = logic [15:0],
    parameter int  DEPTH     = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  word_type                 wr_din,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output word_type                 rd_dout
);

    word_type mem [DEPTH];   // Block RAM array.

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_din;
    end

    // Registered read, old data on a same-address write.
    always_ff @(posedge clk) begin
        rd_dout <= mem[rd_addr];
    end

endmodule

//--- src/free_page_list.sv
`timescale 1ns/100ps

module free_page_list (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         alloc_take,
    output pbuf_pkg::page_t              alloc_page,
    input  logic                         release_vld,
    input  pbuf_pkg::page_t              release_page,
    output logic [pbuf_pkg::PAGE_BITS:0] free_space
);

    pbuf_pkg::page_t              queue [pbuf_pkg::NUM_PAGES];
    pbuf_pkg::page_t              head;        // Wraps at NUM_PAGES.
    pbuf_pkg::page_t              tail;
    logic [pbuf_pkg::PAGE_BITS:0] fill_cnt;    // Next page to seed after reset.
    logic                         filling;
    logic                         push;
    logic                         pop;
    pbuf_pkg::page_t              push_page;

    assign filling   = fill_cnt != pbuf_pkg::NUM_PAGES;
    // Nothing is released while seeding, so the fill owns the push port.
    assign push      = filling || release_vld;
    assign push_page = filling ? pbuf_pkg::page_t'(fill_cnt) : release_page;
    assign pop       = alloc_take && free_space != '0;

    assign alloc_page = queue[head];   // Head shown without a pop.

    always_ff @(posedge clk) begin
        if (push) queue[tail] <= push_page;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            fill_cnt   <= '0;
            free_space <= '0;
        end else begin
            if (filling) fill_cnt <= fill_cnt + 1'b1;
            if (push)    tail     <= tail + 1'b1;
            if (pop)     head     <= head + 1'b1;
            // Push and pop in one cycle leave occupancy as is.
            free_space <= free_space + (pbuf_pkg::PAGE_BITS+1)'(push)
                                     - (pbuf_pkg::PAGE_BITS+1)'(pop);
        end
    end

endmodule

//--- src/pbuf_pkg.sv
package pbuf_pkg;

    localparam int NUM_PAGES  = 64;
    localparam int PAGE_BITS  = 6;
    localparam int PAGE_WORDS = 8;
    localparam int WORD_BITS  = 16;
    localparam int NUM_PORTS  = 16;
    localparam int PORT_BITS  = $clog2(NUM_PORTS);
    localparam int CNT_BITS   = 7;
    localparam int ECC_BITS   = 8;
    localparam int DATA_BITS  = PAGE_WORDS * WORD_BITS;   // 128 protected bits.
    localparam int HAM_LAST   = DATA_BITS + ECC_BITS;     // Highest Hamming position, 136.

    typedef logic [PAGE_BITS-1:0] page_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ECC_BITS-1:0]  ecc_t;
    typedef logic [PORT_BITS-1:0] port_t;

    // Data RAM address, page in the upper bits.
    typedef struct packed {
        page_t      page;
        logic [2:0] word;
    } data_addr_t;

    // Chain entry, one per page.
    typedef struct packed {
        page_t      next;
        logic       last;       // Final page of the packet.
        logic [2:0] last_idx;   // Last valid word, 7 on a full page.
    } link_t;

    typedef struct packed {
        word_t data;
        logic  fixed;           // A bit of this word was corrected.
    } rd_word_t;

    // Check bits sit at the power-of-two positions, data fills the rest.
    // The code is the XOR of the positions of all set data bits.
    function automatic ecc_t ecc_encode(input word_t [PAGE_WORDS-1:0] words);
        logic [DATA_BITS-1:0] bits;
        ecc_t                 code;
        int                   d;
        bits = words;
        code = '0;
        d    = 0;
        for (int p = 1; p <= HAM_LAST; p++) begin
            if ((p & (p - 1)) != 0) begin   // Skip check positions.
                if (bits[d]) code ^= ecc_t'(p);
                d++;
            end
        end
        return code;
    endfunction

    // Nonzero result is the position of the flipped bit.
    function automatic ecc_t ecc_syndrome(input word_t [PAGE_WORDS-1:0] words,
                                          input ecc_t code);
        return ecc_encode(words) ^ code;
    endfunction

endpackage

//--- src/pbuf_top.sv
`timescale 1ns/100ps

module pbuf_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_vld,
    input  pbuf_pkg::word_t               wr_data,
    input  logic                          wr_eop,
    output logic                          wr_head_vld,
    output pbuf_pkg::page_t               wr_head,
    output pbuf_pkg::port_t               wr_head_port,
    input  logic                          rd_req,
    input  pbuf_pkg::page_t               rd_head,
    output logic                          rd_ack,
    output logic                          rd_vld,
    output pbuf_pkg::rd_word_t            rd_word,
    output logic                          rd_eop,
    input  pbuf_pkg::port_t               check_port,
    output logic [pbuf_pkg::CNT_BITS-1:0] check_amount,
    output logic [pbuf_pkg::PAGE_BITS:0]  free_space
);

    logic                 alloc_take, release_vld;
    pbuf_pkg::page_t      alloc_page, release_page;
    logic                 data_we, ecc_we, link_we;
    pbuf_pkg::data_addr_t data_waddr, data_raddr;
    pbuf_pkg::page_t      ecc_waddr, ecc_raddr, link_waddr, link_raddr;
    pbuf_pkg::word_t      data_wdata, data_rdata;
    pbuf_pkg::ecc_t       ecc_wdata, ecc_rdata;
    pbuf_pkg::link_t      link_wdata, link_rdata;
    logic                 pkt_stored_vld, pkt_read_vld;
    pbuf_pkg::port_t      pkt_stored_port, pkt_read_port;

    free_page_list free_list_i (.*);

    pkt_ingress ingress_i (.*);

    pkt_egress egress_i (.*);

    port_stats stats_i (.*);

    // Page storage, one word per data_addr_t.
    dp_ram #(.word_type(pbuf_pkg::word_t), .DEPTH(pbuf_pkg::NUM_PAGES * pbuf_pkg::PAGE_WORDS))
    data_ram_i (.clk, .wr_en(data_we), .wr_addr(data_waddr), .wr_din(data_wdata),
                .rd_addr(data_raddr), .rd_dout(data_rdata));

    // One code per page.
    dp_ram #(.word_type(pbuf_pkg::ecc_t), .DEPTH(pbuf_pkg::NUM_PAGES))
    ecc_ram_i (.clk, .wr_en(ecc_we), .wr_addr(ecc_waddr), .wr_din(ecc_wdata),
               .rd_addr(ecc_raddr), .rd_dout(ecc_rdata));

    // Page chain.
    dp_ram #(.word_type(pbuf_pkg::link_t), .DEPTH(pbuf_pkg::NUM_PAGES))
    link_ram_i (.clk, .wr_en(link_we), .wr_addr(link_waddr), .wr_din(link_wdata),
                .rd_addr(link_raddr), .rd_dout(link_rdata));

endmodule

//--- src/pkt_egress.sv
`timescale 1ns/100ps

module pkt_egress (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rd_req,
    input  pbuf_pkg::page_t      rd_head,
    output logic                 rd_ack,
    output pbuf_pkg::data_addr_t data_raddr,
    output pbuf_pkg::page_t      ecc_raddr,
    output pbuf_pkg::page_t      link_raddr,
    input  pbuf_pkg::word_t      data_rdata,
    input  pbuf_pkg::ecc_t       ecc_rdata,
    input  pbuf_pkg::link_t      link_rdata,
    output logic                 rd_vld,
    output pbuf_pkg::rd_word_t   rd_word,
    output logic                 rd_eop,
    output logic                 release_vld,
    output pbuf_pkg::page_t      release_page,
    output logic                 pkt_read_vld,
    output pbuf_pkg::port_t      pkt_read_port
);

    typedef enum logic [2:0] {IDLE, LOAD, CORRECT, EMIT, ACK} state_t;

    state_t                                     state;
    logic [3:0]                                 ld_cnt;     // 0..7 address, 8 last capture.
    logic [2:0]                                 ld_slot;
    logic [2:0]                                 emit_idx;
    logic                                       first_page;
    logic                                       emit_end;
    pbuf_pkg::page_t                            cur_page;
    pbuf_pkg::word_t [pbuf_pkg::PAGE_WORDS-1:0] page_buf;
    pbuf_pkg::link_t                            link_q;
    pbuf_pkg::port_t                            port_q;
    pbuf_pkg::ecc_t                             syndrome;
    logic                                       flip_hit;
    logic [6:0]                                 flip_bit;   // Word in [6:4], bit in [3:0].
    logic                                       fix_hit;
    logic [2:0]                                 fix_word;

    assign ld_slot    = 3'(ld_cnt - 4'd1);   // Data lags the address by one.
    assign data_raddr = '{page: cur_page, word: ld_cnt[2:0]};
    assign ecc_raddr  = cur_page;
    assign link_raddr = cur_page;

    // Map the syndrome back to a data bit. Check-bit positions match nothing.
    // Slots past the last valid word were encoded as zero.
    always_comb begin : find_flip
        int                                         d;
        pbuf_pkg::word_t [pbuf_pkg::PAGE_WORDS-1:0] used_words;
        d          = 0;
        flip_hit   = 1'b0;
        flip_bit   = '0;
        used_words = page_buf;
        for (int w = 0; w < pbuf_pkg::PAGE_WORDS; w++) begin
            if (w > link_rdata.last_idx) used_words[w] = '0;   // Stale RAM words.
        end
        syndrome = pbuf_pkg::ecc_syndrome(used_words, ecc_rdata);
        for (int p = 1; p <= pbuf_pkg::HAM_LAST; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (syndrome == pbuf_pkg::ecc_t'(p)) begin
                    flip_hit = 1'b1;
                    flip_bit = 7'(d);
                end
                d++;
            end
        end
    end

    assign emit_end = emit_idx == link_q.last_idx;
    assign rd_vld   = state == EMIT;
    assign rd_word  = '{data: page_buf[emit_idx], fixed: fix_hit && fix_word == emit_idx};
    assign rd_eop   = rd_vld && emit_end && link_q.last;
    assign rd_ack   = state == ACK;

    assign release_vld   = rd_vld && emit_end;   // Page fully buffered and sent.
    assign release_page  = cur_page;
    assign pkt_read_vld  = rd_eop;
    assign pkt_read_port = port_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            ld_cnt     <= '0;
            emit_idx   <= '0;
            first_page <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    first_page <= 1'b1;
                    if (rd_req) state <= LOAD;
                end
                LOAD: begin
                    if (ld_cnt == 4'd8) begin
                        state  <= CORRECT;
                        ld_cnt <= '0;
                    end else begin
                        ld_cnt <= ld_cnt + 4'd1;
                    end
                end
                CORRECT: begin
                    state      <= EMIT;
                    first_page <= 1'b0;
                end
                EMIT: begin
                    if (emit_end) begin
                        emit_idx <= '0;
                        state    <= link_q.last ? ACK : LOAD;   // Follow the chain.
                    end else begin
                        emit_idx <= emit_idx + 3'd1;
                    end
                end
                ACK:     if (!rd_req) state <= IDLE;   // Ack drops a cycle after req.
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) cur_page <= rd_head;
        else if (rd_vld && emit_end) cur_page <= link_q.next;
        if (state == LOAD && ld_cnt != 4'd0) page_buf[ld_slot] <= data_rdata;
        if (state == LOAD && ld_cnt == 4'd1 && first_page)
            port_q <= data_rdata[pbuf_pkg::PORT_BITS-1:0];   // Control word.
        if (state == CORRECT) begin
            link_q   <= link_rdata;
            fix_hit  <= flip_hit;
            fix_word <= flip_bit[6:4];
            if (flip_hit)
                page_buf[flip_bit[6:4]][flip_bit[3:0]] <= ~page_buf[flip_bit[6:4]][flip_bit[3:0]];
        end
    end

endmodule

//--- src/pkt_ingress.sv
`timescale 1ns/100ps

module pkt_ingress (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_vld,
    input  pbuf_pkg::word_t      wr_data,
    input  logic                 wr_eop,
    output logic                 alloc_take,
    input  pbuf_pkg::page_t      alloc_page,
    output logic                 data_we,
    output pbuf_pkg::data_addr_t data_waddr,
    output pbuf_pkg::word_t      data_wdata,
    output logic                 ecc_we,
    output pbuf_pkg::page_t      ecc_waddr,
    output pbuf_pkg::ecc_t       ecc_wdata,
    output logic                 link_we,
    output pbuf_pkg::page_t      link_waddr,
    output pbuf_pkg::link_t      link_wdata,
    output logic                 wr_head_vld,
    output pbuf_pkg::page_t      wr_head,
    output pbuf_pkg::port_t      wr_head_port,
    output logic                 pkt_stored_vld,
    output pbuf_pkg::port_t      pkt_stored_port
);

    typedef enum logic [1:0] {IDLE, FIRST, NEXT} state_t;

    state_t                                     state;
    logic [2:0]                                 word_idx;   // Slot in the current page.
    pbuf_pkg::page_t                            cur_page;
    pbuf_pkg::page_t                            page_now;
    pbuf_pkg::word_t [pbuf_pkg::PAGE_WORDS-1:0] page_buf;   // Encoder input.
    pbuf_pkg::port_t                            pkt_port;
    logic [2:0]                                 eop_idx;
    logic                                       page_end;

    assign alloc_take = wr_vld && word_idx == 3'd0;         // New page per first slot.
    assign page_now   = alloc_take ? alloc_page : cur_page;
    assign page_end   = wr_vld && (word_idx == 3'd7 || wr_eop);

    // Words go straight into the data RAM.
    assign data_we    = wr_vld;
    assign data_waddr = '{page: page_now, word: word_idx};
    assign data_wdata = wr_data;

    assign ecc_wdata = pbuf_pkg::ecc_encode(page_buf);   // Buffer is complete here.

    // The chain entry of a full page waits until its successor is taken.
    // The final page is written the cycle after eop; both never coincide.
    assign link_we    = pkt_stored_vld || (alloc_take && state == NEXT);
    assign link_waddr = pkt_stored_vld ? ecc_waddr : cur_page;
    assign link_wdata = pkt_stored_vld ?
                        pbuf_pkg::link_t'{next: '0, last: 1'b1, last_idx: eop_idx} :
                        pbuf_pkg::link_t'{next: alloc_page, last: 1'b0, last_idx: 3'd7};

    assign wr_head_port    = pkt_port;
    assign pkt_stored_port = pkt_port;   // Held until the next control word.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= IDLE;
            word_idx       <= '0;
            wr_head_vld    <= 1'b0;
            pkt_stored_vld <= 1'b0;
            ecc_we         <= 1'b0;
        end else begin
            wr_head_vld    <= wr_vld && state == IDLE;   // Control word seen.
            pkt_stored_vld <= wr_vld && wr_eop;
            ecc_we         <= page_end;
            if (wr_vld) begin
                word_idx <= wr_eop ? 3'd0 : word_idx + 3'd1;
                case (state)
                    IDLE:    state <= wr_eop ? IDLE : FIRST;
                    FIRST: begin
                        if (wr_eop) state <= IDLE;
                        else if (word_idx == 3'd7) state <= NEXT;
                    end
                    default: if (wr_eop) state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) cur_page <= alloc_page;
        if (wr_vld && state == IDLE) begin
            wr_head  <= alloc_page;
            pkt_port <= wr_data[pbuf_pkg::PORT_BITS-1:0];   // Low bits name the port.
        end
        if (page_end) ecc_waddr <= page_now;
        if (wr_vld && wr_eop) eop_idx <= word_idx;
        if (wr_vld) begin
            if (word_idx == 3'd0) page_buf <= '0;   // Unused slots count as zero.
            page_buf[word_idx] <= wr_data;
        end
    end

endmodule

//--- src/port_stats.sv
`timescale 1ns/100ps

module port_stats (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pkt_stored_vld,
    input  pbuf_pkg::port_t               pkt_stored_port,
    input  logic                          pkt_read_vld,
    input  pbuf_pkg::port_t               pkt_read_port,
    input  pbuf_pkg::port_t               check_port,
    output logic [pbuf_pkg::CNT_BITS-1:0] check_amount
);

    logic [pbuf_pkg::CNT_BITS-1:0] counts [pbuf_pkg::NUM_PORTS];   // Stored packets per port.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < pbuf_pkg::NUM_PORTS; p++) counts[p] <= '0;
        end else begin
            for (int p = 0; p < pbuf_pkg::NUM_PORTS; p++) begin
                // Store and read together cancel out.
                if (pkt_stored_vld && pkt_stored_port == p &&
                    !(pkt_read_vld && pkt_read_port == p))
                    counts[p] <= counts[p] + 1'b1;
                else if (pkt_read_vld && pkt_read_port == p &&
                         !(pkt_stored_vld && pkt_stored_port == p))
                    counts[p] <= counts[p] - 1'b1;
            end
        end
    end

    assign check_amount = counts[check_port];

endmodule

//--- verification/pbuf_checker.sv
`timescale 1ns/100ps

module pbuf_checker (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         rd_req,
    input logic                         rd_ack,
    input logic                         rd_vld,
    input logic                         rd_eop,
    input logic                         wr_head_vld,
    input logic [pbuf_pkg::PAGE_BITS:0] free_space
);

    // Ack answers a request that was up on the cycle the packet ended.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rd_ack) |-> $past(rd_req))
        else $error("rd_ack rose without an open rd_req.");

    // Ack follows the last word, with the stream already quiet.
    eop_then_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld && rd_eop |=> rd_ack && !rd_vld)
        else $error("rd_ack did not follow rd_eop with the stream idle.");

    free_space_bound: assert property (@(posedge clk) disable iff (!rst_n)
        free_space <= 7'(pbuf_pkg::NUM_PAGES))
        else $error("free_space is above the number of pages.");

    head_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wr_head_vld |=> !wr_head_vld)
        else $error("wr_head_vld stayed high for more than one cycle.");

endmodule

//--- verification/pbuf_tb.sv
`timescale 1ns/100ps

module pbuf_tb;

    localparam int TIMEOUT_CYCLES = 20000;   // Full run is near 3000 cycles.

    typedef logic [pbuf_pkg::CNT_BITS-1:0] count_t;

    logic clk = 1'b0;
    logic rst_n, wr_vld, wr_eop, rd_req, wr_head_vld, rd_ack, rd_vld, rd_eop;
    pbuf_pkg::word_t    wr_data;
    pbuf_pkg::page_t    wr_head, rd_head;
    pbuf_pkg::port_t    wr_head_port, check_port;
    pbuf_pkg::rd_word_t rd_word;
    count_t             check_amount;
    logic [pbuf_pkg::PAGE_BITS:0] free_space;

    pbuf_pkg::page_t free_q[$];                    // Free page queue model.
    pbuf_pkg::word_t slot_data [4][24];            // Up to four stored packets.
    pbuf_pkg::page_t slot_page [4][3];
    int              slot_len [4];
    int              port_cnt [pbuf_pkg::NUM_PORTS];
    int              cycles = 0;
    integer          seed = 32'h8e02;
    string           test_name = "reset";

    pbuf_top dut_i (.*);

    bind pbuf_top pbuf_checker checker_i (.*);

    always #20 clk = ~clk;   // 40 ns period.

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) abort_run("Timeout, the tests did not finish in time.");
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "Stopped at the first failure.");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;   // Drive and sample just after the edge.
    endtask

    task automatic compare_word(input pbuf_pkg::rd_word_t exp, input pbuf_pkg::rd_word_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s: word expected %h fixed %b, actual %h fixed %b",
                                test_name, exp.data, exp.fixed, act.data, act.fixed));
    endtask

    task automatic compare_page(input string what, input pbuf_pkg::page_t exp,
                                input pbuf_pkg::page_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s: %s expected %0d, actual %0d",
                                test_name, what, exp, act));
    endtask

    task automatic compare_count(input string what, input count_t exp, input count_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %s: %s expected %0d, actual %0d",
                                test_name, what, exp, act));
    endtask

    task automatic check_status();
        compare_count("free space", count_t'(free_q.size()), count_t'(free_space));
        for (int p = 0; p < pbuf_pkg::NUM_PORTS; p++) begin
            check_port = pbuf_pkg::port_t'(p);
            #1;   // Counter mux is combinational.
            compare_count($sformatf("count of port %0d", p), count_t'(port_cnt[p]), check_amount);
        end
        next_cycle();
    endtask

    task automatic write_packet(input int s, input int len, input pbuf_pkg::port_t port);
        bit seen;
        seen        = 1'b0;
        slot_len[s] = len;
        for (int p = 0; p < (len + 7) / 8; p++) slot_page[s][p] = free_q.pop_front();
        for (int i = 0; i < len; i++) begin
            slot_data[s][i] = pbuf_pkg::word_t'($random(seed));
            if (i == 0) slot_data[s][i][pbuf_pkg::PORT_BITS-1:0] = port;   // Control word.
            wr_vld  = 1'b1;
            wr_data = slot_data[s][i];
            wr_eop  = (i == len - 1);
            next_cycle();
            if (wr_head_vld) begin
                seen = 1'b1;
                compare_page("head page", slot_page[s][0], wr_head);
                compare_count("head port", count_t'(port), count_t'(wr_head_port));
            end
        end
        wr_vld = 1'b0;
        wr_eop = 1'b0;
        next_cycle();   // Code, link and counter land here.
        next_cycle();
        if (!seen) abort_run("No head page was reported for a stored packet.");
        port_cnt[port]++;
    endtask

    task automatic read_packet(input int s, input int bad_word);
        int                 n;
        pbuf_pkg::rd_word_t exp;
        n       = 0;
        rd_req  = 1'b1;
        rd_head = slot_page[s][0];
        while (!rd_ack) begin
            next_cycle();
            if (rd_vld) begin
                if (n >= slot_len[s]) abort_run("The read returned more words than were stored.");
                exp = '{data: slot_data[s][n], fixed: n == bad_word};
                compare_word(exp, rd_word);
                if (rd_eop != (n == slot_len[s] - 1)) abort_run("rd_eop is not on the last word.");
                n++;
            end
        end
        if (n != slot_len[s]) abort_run("The read ended before all words came back.");
        rd_req = 1'b0;
        while (rd_ack) next_cycle();
        for (int p = 0; p < (slot_len[s] + 7) / 8; p++) free_q.push_back(slot_page[s][p]);
        port_cnt[slot_data[s][0][pbuf_pkg::PORT_BITS-1:0]]--;
    endtask

    task automatic test_reset();
        repeat (pbuf_pkg::NUM_PAGES + 2) next_cycle();   // Free list refill.
        if (rd_vld || rd_ack) abort_run("Read outputs are active after reset.");
        check_status();
    endtask

    task automatic test_single();
        test_name = "single page";
        write_packet(0, 3, 4'd5);
        check_status();
        read_packet(0, -1);
        check_status();
    endtask

    task automatic test_multi();
        test_name = "multi page";
        write_packet(0, 20, 4'd2);   // Three pages.
        check_status();
        write_packet(1, 8, 4'd9);    // Exactly one full page.
        check_status();
        read_packet(1, -1);
        check_status();
        read_packet(0, -1);
        check_status();
    endtask

    task automatic test_ecc();
        int addr;
        test_name = "ecc correction";
        write_packet(0, 10, 4'd12);
        addr = slot_page[0][1] * pbuf_pkg::PAGE_WORDS + 1;   // Word 9, in the partial page.
        dut_i.data_ram_i.mem[addr] = dut_i.data_ram_i.mem[addr] ^ 16'h0800;
        read_packet(0, 9);
        check_status();
    endtask

    task automatic test_random();
        int pend[$];   // Slots stored and not yet read.
        int idle[$];
        int s;
        int pick;
        test_name = "random traffic";
        idle = '{0, 1, 2, 3};
        for (int k = 0; k < 30; k++) begin
            if (pend.size() == 4 || (pend.size() > 0 && $random(seed) % 2 == 0)) begin
                pick = $unsigned($random(seed)) % pend.size();
                s    = pend[pick];
                pend.delete(pick);
                read_packet(s, -1);
                idle.push_back(s);
                check_status();
            end
            s = idle.pop_front();
            write_packet(s, 1 + $unsigned($random(seed)) % 24, pbuf_pkg::port_t'($random(seed)));
            pend.push_back(s);
            check_status();
        end
        while (pend.size() > 0) begin
            read_packet(pend.pop_front(), -1);
            check_status();
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        wr_vld     = 1'b0;
        wr_data    = '0;
        wr_eop     = 1'b0;
        rd_req     = 1'b0;
        rd_head    = '0;
        check_port = '0;
        for (int p = 0; p < pbuf_pkg::NUM_PAGES; p++) free_q.push_back(pbuf_pkg::page_t'(p));
        foreach (port_cnt[p]) port_cnt[p] = 0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        test_reset();
        test_single();
        test_multi();
        test_ecc();
        test_random();
        $display("All checks passed");
        $finish;
    end

endmodule
